//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU ops, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;        // Also SUB with funct7[5]
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;        // SRL or SRA by funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // mcause values
    localparam logic [31:0] CAUSE_INSTR_MISALIGNED = 32'd0;
    localparam logic [31:0] CAUSE_ILLEGAL          = 32'd2;
    localparam logic [31:0] CAUSE_BREAKPOINT       = 32'd3;
    localparam logic [31:0] CAUSE_ECALL_M          = 32'd11;
    localparam logic [31:0] CAUSE_EXT_INTERRUPT    = 32'h8000000B;  // Interrupt bit set

    // Field layouts, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_t;

endpackage

//--- rtl/exu_pkg.sv
package exu_pkg;

    // ALU output select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_sel_t;

    typedef enum logic {IN0_RS1, IN0_PC} in0_sel_t;     // Operand 0 source
    typedef enum logic {IN1_RS2, IN1_IMM} in1_sel_t;    // Operand 1 source

    // Register write data source
    typedef enum logic [1:0] {RD_ALU, RD_IMM, RD_PC_PLUS_4} rd_sel_t;

    // Instruction class as seen by the result stage
    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_JUMP,
        KIND_BRANCH,
        KIND_ECALL,
        KIND_EBREAK,
        KIND_ILLEGAL
    } kind_t;

    // Command to the surrounding pipeline
    typedef enum logic [1:0] {CMD_NONE, CMD_BRANCH, CMD_TRAP} cmd_t;

    // Decode to execute slot
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [31:0] imm;
        logic [4:0]  rd_addr;
        logic [2:0]  funct3;             // Branch condition
        kind_t       kind;
        alu_sel_t    alu_sel;
        in0_sel_t    in0_sel;
        in1_sel_t    in1_sel;
        rd_sel_t     rd_sel;
        logic        interrupt_pending;
        logic        fetch_exception;
        logic [31:0] fetch_cause;
    } d2e_t;

    // Execute to result slot
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] imm;                // LUI data
        logic [4:0]  rd_addr;
        kind_t       kind;
        rd_sel_t     rd_sel;
        logic        branch_taken;
        logic [31:0] jump_target;
        logic        interrupt_pending;
        logic        fetch_exception;
        logic [31:0] fetch_cause;
    } e2r_t;

endpackage

//--- rtl/exu_decode.sv
`timescale 1ns/1ps

module exu_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           pc,
    input  rv_isa_pkg::rv_instr_t instr,
    input  logic [31:0]           rs1_rdata,
    input  logic [31:0]           rs2_rdata,
    input  logic                  interrupt_pending,
    input  logic                  fetch_exception,
    input  logic [31:0]           fetch_cause,
    output exu_pkg::d2e_t         d2e
);

    logic [31:0]       imm_i, imm_b, imm_u, imm_j;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              f7_zero, f7_alt;
    logic              sys_base;
    exu_pkg::alu_sel_t alu_f3;
    exu_pkg::d2e_t     d2e_nxt;

    assign f3      = instr.r_fmt.funct3;
    assign f7      = instr.r_fmt.funct7;
    assign f7_zero = (f7 == 7'b0000000);
    assign f7_alt  = (f7 == 7'b0100000);            // SUB / SRA encoding

    // Sign extended immediates by format
    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    // ECALL and EBREAK share everything but imm[0]
    assign sys_base = (instr.i_fmt.rs1 == 5'd0) && (f3 == 3'd0) && (instr.i_fmt.rd == 5'd0);

    // ALU op from funct3 and funct7[5]
    always_comb begin
        case (f3)
            rv_isa_pkg::F3_SLL:  alu_f3 = exu_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  alu_f3 = exu_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: alu_f3 = exu_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  alu_f3 = exu_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   alu_f3 = f7[5] ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   alu_f3 = exu_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:  alu_f3 = exu_pkg::ALU_AND;
            default:             alu_f3 = exu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        d2e_nxt                   = '0;
        d2e_nxt.valid             = instr_valid;
        d2e_nxt.pc                = pc;
        d2e_nxt.rs1_rdata         = rs1_rdata;
        d2e_nxt.rs2_rdata         = rs2_rdata;
        d2e_nxt.rd_addr           = instr.r_fmt.rd;
        d2e_nxt.funct3            = f3;
        d2e_nxt.interrupt_pending = interrupt_pending;
        d2e_nxt.fetch_exception   = fetch_exception;
        d2e_nxt.fetch_cause       = fetch_cause;
        d2e_nxt.imm               = imm_i;         // Most common format
        d2e_nxt.kind              = exu_pkg::KIND_ILLEGAL;  // Unless proven otherwise
        d2e_nxt.alu_sel           = exu_pkg::ALU_ADD;
        d2e_nxt.in0_sel           = exu_pkg::IN0_RS1;
        d2e_nxt.in1_sel           = exu_pkg::IN1_IMM;
        d2e_nxt.rd_sel            = exu_pkg::RD_ALU;

        case (instr.r_fmt.opcode)
            rv_isa_pkg::OPC_LUI: begin
                d2e_nxt.kind   = exu_pkg::KIND_ALU;
                d2e_nxt.imm    = imm_u;
                d2e_nxt.rd_sel = exu_pkg::RD_IMM;   // ALU bypassed
            end
            rv_isa_pkg::OPC_AUIPC: begin
                d2e_nxt.kind    = exu_pkg::KIND_ALU;
                d2e_nxt.imm     = imm_u;
                d2e_nxt.in0_sel = exu_pkg::IN0_PC;
            end
            rv_isa_pkg::OPC_JAL: begin
                d2e_nxt.kind    = exu_pkg::KIND_JUMP;
                d2e_nxt.imm     = imm_j;
                d2e_nxt.in0_sel = exu_pkg::IN0_PC;  // Marks pc-relative target
                d2e_nxt.rd_sel  = exu_pkg::RD_PC_PLUS_4;
            end
            rv_isa_pkg::OPC_JALR: begin
                if (f3 == 3'd0) begin
                    d2e_nxt.kind   = exu_pkg::KIND_JUMP;  // rs1 + imm via ALU
                    d2e_nxt.rd_sel = exu_pkg::RD_PC_PLUS_4;
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                d2e_nxt.imm = imm_b;
                if (f3 != 3'b010 && f3 != 3'b011) begin  // Two holes in funct3
                    d2e_nxt.kind = exu_pkg::KIND_BRANCH;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                d2e_nxt.alu_sel = alu_f3;
                // Only shifts constrain funct7
                if ((f3 == rv_isa_pkg::F3_SLL && !f7_zero) ||
                    (f3 == rv_isa_pkg::F3_SR && !f7_zero && !f7_alt)) begin
                    d2e_nxt.kind = exu_pkg::KIND_ILLEGAL;
                end else begin
                    d2e_nxt.kind = exu_pkg::KIND_ALU;
                end
            end
            rv_isa_pkg::OPC_OP: begin
                d2e_nxt.in1_sel = exu_pkg::IN1_RS2;
                d2e_nxt.alu_sel = (f3 == rv_isa_pkg::F3_ADD && f7_alt) ? exu_pkg::ALU_SUB
                                                                       : alu_f3;
                if (f7_zero || (f7_alt && (f3 == rv_isa_pkg::F3_ADD ||
                                           f3 == rv_isa_pkg::F3_SR))) begin
                    d2e_nxt.kind = exu_pkg::KIND_ALU;
                end
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                if (sys_base && instr.i_fmt.imm_11_0 == 12'h000) begin
                    d2e_nxt.kind = exu_pkg::KIND_ECALL;
                end else if (sys_base && instr.i_fmt.imm_11_0 == 12'h001) begin
                    d2e_nxt.kind = exu_pkg::KIND_EBREAK;
                end             // CSR ops stay illegal
            end
            default: ;          // Loads, stores, FENCE, AMO etc. trap
        endcase
    end

    always_ff @(posedge clk) begin
        d2e <= d2e_nxt;
        if (rst_n) begin
            d2e.valid <= 1'b0;  // Slot empty in reset
        end
    end

endmodule

//--- rtl/exu_execute.sv
`timescale 1ns/1ps

module exu_execute (
    input  logic          clk,
    input  logic          rst_n,
    input  exu_pkg::d2e_t d2e,
    output exu_pkg::e2r_t e2r
);

    logic [31:0]   op0, op1;
    logic [31:0]   alu_result;
    logic [31:0]   pc_rel_target;
    logic [31:0]   jump_target;
    logic [4:0]    shamt;
    logic          branch_cond;
    exu_pkg::e2r_t e2r_nxt;

    // Operand muxes
    assign op0   = (d2e.in0_sel == exu_pkg::IN0_PC) ? d2e.pc : d2e.rs1_rdata;
    assign op1   = (d2e.in1_sel == exu_pkg::IN1_IMM) ? d2e.imm : d2e.rs2_rdata;
    assign shamt = op1[4:0];                        // rs2 or imm[4:0]

    always_comb begin
        case (d2e.alu_sel)
            exu_pkg::ALU_SUB:  alu_result = op0 - op1;
            exu_pkg::ALU_SLL:  alu_result = op0 << shamt;
            exu_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op0) < $signed(op1)};
            exu_pkg::ALU_SLTU: alu_result = {31'b0, op0 < op1};
            exu_pkg::ALU_XOR:  alu_result = op0 ^ op1;
            exu_pkg::ALU_SRL:  alu_result = op0 >> shamt;
            exu_pkg::ALU_SRA:  alu_result = $unsigned($signed(op0) >>> shamt);
            exu_pkg::ALU_OR:   alu_result = op0 | op1;
            exu_pkg::ALU_AND:  alu_result = op0 & op1;
            default:           alu_result = op0 + op1;   // ADD, also AUIPC and JALR
        endcase
    end

    // Branch compare on raw register values
    always_comb begin
        case (d2e.funct3)
            rv_isa_pkg::F3_BEQ:  branch_cond = (d2e.rs1_rdata == d2e.rs2_rdata);
            rv_isa_pkg::F3_BNE:  branch_cond = (d2e.rs1_rdata != d2e.rs2_rdata);
            rv_isa_pkg::F3_BLT:  branch_cond = $signed(d2e.rs1_rdata) < $signed(d2e.rs2_rdata);
            rv_isa_pkg::F3_BGE:  branch_cond = $signed(d2e.rs1_rdata) >= $signed(d2e.rs2_rdata);
            rv_isa_pkg::F3_BLTU: branch_cond = (d2e.rs1_rdata < d2e.rs2_rdata);
            rv_isa_pkg::F3_BGEU: branch_cond = (d2e.rs1_rdata >= d2e.rs2_rdata);
            default:             branch_cond = 1'b0;    // Decode already flagged it
        endcase
    end

    // JAL and branches are pc relative, JALR is the only jump fed from rs1
    assign pc_rel_target = d2e.pc + d2e.imm;
    assign jump_target   = (d2e.kind == exu_pkg::KIND_JUMP && d2e.in0_sel == exu_pkg::IN0_RS1)
                           ? {alu_result[31:1], 1'b0}
                           : pc_rel_target;

    always_comb begin
        e2r_nxt.valid             = d2e.valid;
        e2r_nxt.pc                = d2e.pc;
        e2r_nxt.alu_result        = alu_result;
        e2r_nxt.imm               = d2e.imm;
        e2r_nxt.rd_addr           = d2e.rd_addr;
        e2r_nxt.kind              = d2e.kind;
        e2r_nxt.rd_sel            = d2e.rd_sel;
        e2r_nxt.branch_taken      = (d2e.kind == exu_pkg::KIND_BRANCH) && branch_cond;
        e2r_nxt.jump_target       = jump_target;
        e2r_nxt.interrupt_pending = d2e.interrupt_pending;
        e2r_nxt.fetch_exception   = d2e.fetch_exception;
        e2r_nxt.fetch_cause       = d2e.fetch_cause;
    end

    always_ff @(posedge clk) begin
        e2r <= e2r_nxt;
        if (rst_n) begin
            e2r.valid <= 1'b0;
        end
    end

endmodule

//--- rtl/exu_result.sv
`timescale 1ns/1ps

module exu_result (
    input  logic          clk,
    input  logic          rst_n,
    input  exu_pkg::e2r_t e2r,
    output logic          rd_write,
    output logic [4:0]    rd_addr,
    output logic [31:0]   rd_wdata,
    output exu_pkg::cmd_t cmd,
    output logic [31:0]   jump_target,
    output logic [31:0]   trap_cause,
    output logic          ebreak
);

    logic          redirect;
    logic          misaligned;
    logic          trap;
    logic          is_ebreak;
    logic [31:0]   cause;
    logic [31:0]   wdata;
    exu_pkg::cmd_t cmd_nxt;
    logic          rd_write_nxt;

    assign redirect   = (e2r.kind == exu_pkg::KIND_JUMP) || e2r.branch_taken;
    assign misaligned = redirect && (e2r.jump_target[1:0] != 2'b00);

    // Trap priority, highest first
    always_comb begin
        trap      = 1'b1;
        is_ebreak = 1'b0;
        cause     = rv_isa_pkg::CAUSE_INSTR_MISALIGNED;
        if (e2r.interrupt_pending) begin
            cause = rv_isa_pkg::CAUSE_EXT_INTERRUPT;
        end else if (e2r.fetch_exception) begin
            cause = e2r.fetch_cause;                // Passed through untouched
        end else if (e2r.kind == exu_pkg::KIND_ILLEGAL) begin
            cause = rv_isa_pkg::CAUSE_ILLEGAL;
        end else if (e2r.kind == exu_pkg::KIND_ECALL) begin
            cause = rv_isa_pkg::CAUSE_ECALL_M;
        end else if (e2r.kind == exu_pkg::KIND_EBREAK) begin
            cause     = rv_isa_pkg::CAUSE_BREAKPOINT;
            is_ebreak = 1'b1;
        end else if (!misaligned) begin
            trap = 1'b0;                            // Clean retire
        end
    end

    always_comb begin
        case (e2r.rd_sel)
            exu_pkg::RD_IMM:       wdata = e2r.imm;
            exu_pkg::RD_PC_PLUS_4: wdata = e2r.pc + 32'd4;   // Link address
            default:               wdata = e2r.alu_result;
        endcase
    end

    always_comb begin
        if (!e2r.valid) begin
            cmd_nxt = exu_pkg::CMD_NONE;
        end else if (trap) begin
            cmd_nxt = exu_pkg::CMD_TRAP;
        end else if (redirect) begin
            cmd_nxt = exu_pkg::CMD_BRANCH;
        end else begin
            cmd_nxt = exu_pkg::CMD_NONE;
        end
    end

    // x0 never written, traps never write
    assign rd_write_nxt = e2r.valid && !trap && (e2r.rd_addr != 5'd0) &&
                          (e2r.kind == exu_pkg::KIND_ALU || e2r.kind == exu_pkg::KIND_JUMP);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            rd_write <= 1'b0;
            cmd      <= exu_pkg::CMD_NONE;
            ebreak   <= 1'b0;
        end else begin
            rd_write <= rd_write_nxt;
            cmd      <= cmd_nxt;
            ebreak   <= e2r.valid && is_ebreak;     // Single cycle per EBREAK
        end
    end

    // Data side, qualified by cmd and rd_write
    always_ff @(posedge clk) begin
        rd_addr     <= e2r.rd_addr;
        rd_wdata    <= wdata;
        jump_target <= e2r.jump_target;
        trap_cause  <= cause;
    end

endmodule

//--- rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           pc,
    input  rv_isa_pkg::rv_instr_t instr,
    input  logic [31:0]           rs1_rdata,
    input  logic [31:0]           rs2_rdata,
    input  logic                  interrupt_pending,
    input  logic                  fetch_exception,
    input  logic [31:0]           fetch_cause,
    output logic                  rd_write,
    output logic [4:0]            rd_addr,
    output logic [31:0]           rd_wdata,
    output exu_pkg::cmd_t         cmd,
    output logic [31:0]           jump_target,
    output logic [31:0]           trap_cause,
    output logic                  ebreak
);

    exu_pkg::d2e_t d2e;     // Decode to execute slot
    exu_pkg::e2r_t e2r;     // Execute to result slot

    exu_decode exu_decode_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr_valid       (instr_valid),
        .pc                (pc),
        .instr             (instr),
        .rs1_rdata         (rs1_rdata),
        .rs2_rdata         (rs2_rdata),
        .interrupt_pending (interrupt_pending),
        .fetch_exception   (fetch_exception),
        .fetch_cause       (fetch_cause),
        .d2e               (d2e)
    );

    exu_execute exu_execute_i (
        .clk   (clk),
        .rst_n (rst_n),
        .d2e   (d2e),
        .e2r   (e2r)
    );

    exu_result exu_result_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .e2r         (e2r),
        .rd_write    (rd_write),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .cmd         (cmd),
        .jump_target (jump_target),
        .trap_cause  (trap_cause),
        .ebreak      (ebreak)
    );

endmodule

//--- verif/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_SLOTS      = 2000;
    localparam int TIMEOUT_CYCLES = 2100;     // Reset, slots and drain plus margin

    // Expected output set for one slot
    typedef struct packed {
        logic          rd_write;
        logic [4:0]    rd_addr;
        logic [31:0]   rd_wdata;
        exu_pkg::cmd_t cmd;
        logic [31:0]   jump_target;
        logic [31:0]   trap_cause;
        logic          ebreak;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  instr_valid;
    logic [31:0]           pc;
    rv_isa_pkg::rv_instr_t instr;
    logic [31:0]           rs1_rdata, rs2_rdata;
    logic                  interrupt_pending, fetch_exception;
    logic [31:0]           fetch_cause;
    logic                  rd_write, ebreak;
    logic [4:0]            rd_addr;
    logic [31:0]           rd_wdata, jump_target, trap_cause;
    exu_pkg::cmd_t         cmd;
    exp_t                  exp_s1, exp_s2, exp_out;     // Expected pipe as deep as the DUT
    int                    cycle_count = 0;
    logic                  armed = 1'b0;                // No checks before the first edge

    always #50 clk = ~clk;

    exu_top exu_top_i (.*);

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
        fail_run();
    endtask

    // RV32I ALU op with alt taken from instr[30]
    function automatic logic [31:0] alu_value(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return 32'($signed(x) < $signed(y));
            3'd3:    return 32'(x < y);
            3'd4:    return x ^ y;
            3'd5:    return (x >> y[4:0]) |            // Top bits filled for SRA
                            ({32{alt && x[31]}} & ~(32'hffff_ffff >> y[4:0]));
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            rv_isa_pkg::F3_BEQ:  return a == b;
            rv_isa_pkg::F3_BNE:  return a != b;
            rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
            rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            rv_isa_pkg::F3_BLTU: return a < b;
            rv_isa_pkg::F3_BGEU: return a >= b;
            default:             return 1'b0;
        endcase
    endfunction

    // Reference model straight from the ISA encoding
    function automatic exp_t expected_outputs(input logic valid, input logic [31:0] pc_in,
            input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
            input logic irq, input logic fexc, input logic [31:0] fcause);
        exp_t        e;
        logic [31:0] imm_i, imm_b, imm_u, imm_j, val, tgt;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal, writes, redirect, trap, is_ecall, is_ebreak;
        e         = '0;
        f3        = w[14:12];
        f7        = w[31:25];
        imm_i     = {{20{w[31]}}, w[31:20]};
        imm_b     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u     = {w[31:12], 12'h000};
        imm_j     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        legal     = 1'b1;
        writes    = 1'b1;       // Cleared for branch and system
        redirect  = 1'b0;
        val       = '0;
        tgt       = '0;
        is_ecall  = 1'b0;
        is_ebreak = 1'b0;
        case (w[6:0])
            rv_isa_pkg::OPC_LUI:   val = imm_u;
            rv_isa_pkg::OPC_AUIPC: val = pc_in + imm_u;
            rv_isa_pkg::OPC_JAL: begin
                val      = pc_in + 32'd4;
                tgt      = pc_in + imm_j;
                redirect = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                legal    = (f3 == 3'd0);
                val      = pc_in + 32'd4;
                tgt      = (a + imm_i) & 32'hffff_fffe;   // Bit 0 dropped
                redirect = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                legal    = (f3 != 3'd2) && (f3 != 3'd3);
                writes   = 1'b0;
                tgt      = pc_in + imm_b;
                redirect = branch_taken(f3, a, b);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                val = alu_value(f3, (f3 == 3'd5) && w[30], a, imm_i);
            end
            rv_isa_pkg::OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                val   = alu_value(f3, w[30], a, b);
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                writes    = 1'b0;
                is_ecall  = (w == 32'h0000_0073);
                is_ebreak = (w == 32'h0010_0073);
                legal     = is_ecall || is_ebreak;      // CSR ops trap
            end
            default: legal = 1'b0;                      // Load, store, FENCE, unknown
        endcase

        // Trap priority from highest down
        trap = 1'b1;
        if (irq) begin
            e.trap_cause = rv_isa_pkg::CAUSE_EXT_INTERRUPT;
        end else if (fexc) begin
            e.trap_cause = fcause;
        end else if (!legal) begin
            e.trap_cause = rv_isa_pkg::CAUSE_ILLEGAL;
        end else if (is_ecall) begin
            e.trap_cause = rv_isa_pkg::CAUSE_ECALL_M;
        end else if (is_ebreak) begin
            e.trap_cause = rv_isa_pkg::CAUSE_BREAKPOINT;
            e.ebreak     = valid;
        end else if (redirect && tgt[1:0] != 2'b00) begin
            e.trap_cause = rv_isa_pkg::CAUSE_INSTR_MISALIGNED;
        end else begin
            trap = 1'b0;
        end

        if (!valid) begin
            e.cmd = exu_pkg::CMD_NONE;
        end else if (trap) begin
            e.cmd = exu_pkg::CMD_TRAP;
        end else if (redirect) begin
            e.cmd = exu_pkg::CMD_BRANCH;
        end
        e.rd_write    = valid && !trap && writes && (w[11:7] != 5'd0);
        e.rd_addr     = w[11:7];
        e.rd_wdata    = val;
        e.jump_target = tgt;
        return e;
    endfunction

    function automatic logic [6:0] legal_funct7();
        return ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
    endfunction

    // One random slot with the opcode mix weighted toward kept instructions
    task automatic drive_random();
        rv_isa_pkg::rv_instr_t ins;
        int                    pick;
        ins  = $urandom;
        pick = $urandom_range(0, 15);
        case (pick)
            0:       ins.u_fmt.opcode = rv_isa_pkg::OPC_LUI;
            1:       ins.u_fmt.opcode = rv_isa_pkg::OPC_AUIPC;
            2:       ins.j_fmt.opcode = rv_isa_pkg::OPC_JAL;
            3: begin
                ins.i_fmt.opcode = rv_isa_pkg::OPC_JALR;
                if ($urandom_range(0, 7) != 0) begin
                    ins.i_fmt.funct3 = 3'd0;            // Mostly legal JALR
                end
            end
            4, 5:    ins.b_fmt.opcode = rv_isa_pkg::OPC_BRANCH;
            6, 7: begin
                ins.i_fmt.opcode = rv_isa_pkg::OPC_OP_IMM;
                if ($urandom_range(0, 3) != 0) begin
                    ins.r_fmt.funct7 = legal_funct7();  // Shifts need a clean funct7
                end
            end
            8, 9: begin
                ins.r_fmt.opcode = rv_isa_pkg::OPC_OP;
                if ($urandom_range(0, 7) != 0) begin
                    ins.r_fmt.funct7 = legal_funct7();
                end
            end
            10, 11: begin
                ins                = '0;                // ECALL or EBREAK by imm
                ins.i_fmt.opcode   = rv_isa_pkg::OPC_SYSTEM;
                ins.i_fmt.imm_11_0 = (pick == 11) ? 12'h001 : 12'h000;
            end
            12:      ins.i_fmt.opcode = rv_isa_pkg::OPC_SYSTEM;     // CSR space
            13:      ins.i_fmt.opcode = 7'b0000011;                 // Load
            14:      ins.s_fmt.opcode = 7'b0100011;                 // Store
            default: ins.i_fmt.opcode = 7'b0001111;                 // FENCE
        endcase
        instr_valid       = ($urandom_range(0, 7) != 0);
        pc                = $urandom & 32'hffff_fffc;
        instr             = ins;
        rs1_rdata         = $urandom;
        rs2_rdata         = ($urandom_range(0, 3) == 0) ? rs1_rdata : $urandom;
        interrupt_pending = ($urandom_range(0, 15) == 0);
        fetch_exception   = ($urandom_range(0, 15) == 0);
        fetch_cause       = $urandom_range(0, 15);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            exp_s1  <= '0;
            exp_s2  <= '0;
            exp_out <= '0;
        end else begin
            exp_s1  <= expected_outputs(instr_valid, pc, instr, rs1_rdata, rs2_rdata,
                                        interrupt_pending, fetch_exception, fetch_cause);
            exp_s2  <= exp_s1;
            exp_out <= exp_s2;
        end
    end

    always @(posedge clk) begin
        armed       <= 1'b1;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // Checked on the falling edge where outputs are settled
    cmd_check: assert property (@(negedge clk) armed |-> cmd == exp_out.cmd)
        else value_mismatch("cmd", 32'(cmd), 32'(exp_out.cmd));
    rd_write_check: assert property (@(negedge clk) armed |-> rd_write == exp_out.rd_write)
        else value_mismatch("rd_write", 32'(rd_write), 32'(exp_out.rd_write));
    ebreak_check: assert property (@(negedge clk) armed |-> ebreak == exp_out.ebreak)
        else value_mismatch("ebreak", 32'(ebreak), 32'(exp_out.ebreak));
    rd_addr_check: assert property (@(negedge clk)
            armed && exp_out.rd_write |-> rd_addr == exp_out.rd_addr)
        else value_mismatch("rd_addr", 32'(rd_addr), 32'(exp_out.rd_addr));
    rd_wdata_check: assert property (@(negedge clk)
            armed && exp_out.rd_write |-> rd_wdata == exp_out.rd_wdata)
        else value_mismatch("rd_wdata", rd_wdata, exp_out.rd_wdata);
    target_check: assert property (@(negedge clk)
            armed && exp_out.cmd == exu_pkg::CMD_BRANCH |-> jump_target == exp_out.jump_target)
        else value_mismatch("jump_target", jump_target, exp_out.jump_target);
    cause_check: assert property (@(negedge clk)
            armed && exp_out.cmd == exu_pkg::CMD_TRAP |-> trap_cause == exp_out.trap_cause)
        else value_mismatch("trap_cause", trap_cause, exp_out.trap_cause);

    initial begin
        void'($urandom(32'h3c97_3d12));
        rst_n             = 1'b1;                   // Active high despite the name
        instr_valid       = 1'b0;
        pc                = '0;
        instr             = '0;
        rs1_rdata         = '0;
        rs2_rdata         = '0;
        interrupt_pending = 1'b0;
        fetch_exception   = 1'b0;
        fetch_cause       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        for (int n = 0; n < NUM_SLOTS; n++) begin
            drive_random();
            @(negedge clk);
        end
        instr_valid = 1'b0;                         // Drain the last three slots
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- exu_top.f
rtl/rv_isa_pkg.sv
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_execute.sv
rtl/exu_result.sv
rtl/exu_top.sv
verif/exu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the exu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exu_top.f --top-module exu_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vexu_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
